/* Makefile */
VERILATOR ?= verilator
TOP       ?= mem_stage_tb
FILELIST  ?= mem_stage.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --timing --assert -Wno-fatal

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FILELIST)
	./$(BUILD_DIR)/V$(TOP)

clean:
	rm -rf $(BUILD_DIR)

/* logic/cp0_pkg.sv */
`default_nettype none

package cp0_pkg;

	typedef enum logic [1:0] {
		CP0_NONE = 2'd0,
		CP0_MTC0 = 2'd1,
		CP0_EXC  = 2'd2,
		CP0_ERET = 2'd3
	} cp0_op_t;

	// Cause.ExcCode values
	typedef enum logic [4:0] {
		EXC_INT  = 5'd0,
		EXC_ADEL = 5'd4,
		EXC_ADES = 5'd5,
		EXC_SYS  = 5'd8,
		EXC_BP   = 5'd9,
		EXC_RI   = 5'd10,
		EXC_OV   = 5'd12
	} exc_code_t;

	typedef enum logic [4:0] {
		REG_BADVADDR = 5'd8,
		REG_COUNT    = 5'd9,
		REG_COMPARE  = 5'd11,
		REG_STATUS   = 5'd12,
		REG_CAUSE    = 5'd13,
		REG_EPC      = 5'd14
	} cp0_reg_t;

	typedef struct packed {
		logic [8:0] rsv_31_23;
		logic       bev;
		logic [5:0] rsv_21_16;
		logic [7:0] im;
		logic [5:0] rsv_7_2;
		logic       exl;
		logic       ie;
	} cp0_status_t;

	// MTC0 writes the raw word, interrupt logic reads fields
	typedef union packed {
		logic [31:0] raw;
		cp0_status_t f;
	} cp0_status_u;

endpackage

`default_nettype wire

/* logic/cp0_regfile.sv */
`timescale 1ns/10ps
`include "mem_config.svh"
`default_nettype none

module cp0_regfile (
	input  wire                     clk,
	input  wire                     rst_n,
	input  wire                     stall,
	input  wire [5:0]               ext_int,
	input  wire cp0_pkg::cp0_op_t   cp0_op,
	input  wire cp0_pkg::exc_code_t exc_code,
	input  wire [31:0]              pc,
	input  wire                     in_delay_slot,
	input  wire                     badvaddr_wen,
	input  wire [31:0]              badvaddr,
	input  wire [4:0]               raddr,
	input  wire [4:0]               waddr,
	input  wire [31:0]              wdata,
	output logic [31:0]             rdata,
	output cp0_pkg::cp0_status_u    status,
	output logic [31:0]             cause,
	output logic [31:0]             epc
);
	import cp0_pkg::*;

	cp0_status_u wr_status;
	logic        upd;
	logic        mtc0_en;
	logic        count_tick;
	logic [3:0]  div_cnt;
	logic [31:0] count;
	logic [31:0] compare;
	logic [31:0] badvaddr_r;
	logic        timer_int;
	logic [5:0]  ip_hw;
	logic [1:0]  ip_sw;
	logic        cause_bd;
	exc_code_t   cause_exc;

	assign wr_status.raw = wdata;
	assign upd           = !stall && cp0_op != CP0_NONE;
	assign mtc0_en       = upd && cp0_op == CP0_MTC0;
	assign count_tick    = div_cnt == 4'(`MEM_COUNT_DIV - 1);

	assign cause = {cause_bd, timer_int, 14'd0, ip_hw, ip_sw, 1'b0, cause_exc, 2'b00};

	// Count runs through stalls
	always_ff @(posedge clk) begin
		if (!rst_n) begin
			div_cnt <= 4'd0;
			count   <= 32'd0;
		end else begin
			div_cnt <= count_tick ? 4'd0 : div_cnt + 4'd1;
			if (mtc0_en && waddr == REG_COUNT) begin
				count <= wdata;
			end else if (count_tick) begin
				count <= count + 32'd1;
			end
		end
	end

	// Timer shares IP7 with ext_int[5]
	always_ff @(posedge clk) begin
		if (!rst_n) begin
			timer_int <= 1'b0;
			ip_hw     <= 6'd0;
		end else begin
			if (mtc0_en && waddr == REG_COMPARE) begin
				timer_int <= 1'b0;
			end else if (count_tick && count + 32'd1 == compare) begin
				timer_int <= 1'b1;
			end
			if (!stall) begin
				ip_hw <= {ext_int[5] | timer_int, ext_int[4:0]};
			end
		end
	end

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			status.raw <= `MEM_STATUS_RESET;
			cause_bd   <= 1'b0;
			cause_exc  <= EXC_INT;
			ip_sw      <= 2'd0;
			epc        <= 32'd0;
			compare    <= 32'd0;
		end else if (upd) begin
			case (cp0_op)
				CP0_EXC: begin
					status.f.exl <= 1'b1;
					cause_bd     <= in_delay_slot;
					cause_exc    <= exc_code;
					// Branch pc when the faulting instruction is in a delay slot
					epc          <= in_delay_slot ? pc - 32'd4 : pc;
				end
				CP0_ERET: begin
					status.f.exl <= 1'b0;
				end
				CP0_MTC0: begin
					case (waddr)
						REG_STATUS: begin
							status.f.bev <= wr_status.f.bev;
							status.f.im  <= wr_status.f.im;
							status.f.exl <= wr_status.f.exl;
							status.f.ie  <= wr_status.f.ie;
						end
						REG_CAUSE:   ip_sw <= wdata[9:8];
						REG_EPC:     epc <= wdata;
						REG_COMPARE: compare <= wdata;
						default: ;
					endcase
				end
				default: ;
			endcase
		end
	end

	always_ff @(posedge clk) begin
		if (upd && badvaddr_wen) begin
			badvaddr_r <= badvaddr;
		end
	end

	always_comb begin
		case (raddr)
			REG_BADVADDR: rdata = badvaddr_r;
			REG_COUNT:    rdata = count;
			REG_COMPARE:  rdata = compare;
			REG_STATUS:   rdata = status.raw;
			REG_CAUSE:    rdata = cause;
			REG_EPC:      rdata = epc;
			default:      rdata = 32'd0;
		endcase
	end

endmodule

`default_nettype wire

/* logic/data_addr_check.sv */
`timescale 1ns/10ps
`default_nettype none

module data_addr_check (
	input  wire                         valid,
	input  wire                         mem_req,
	input  wire                         wr,
	input  wire mem_ops_pkg::mem_size_t size,
	input  wire mem_ops_pkg::part_op_t  part_op,
	input  wire [1:0]                   addr,
	output logic                        addr_err_load,
	output logic                        addr_err_store,
	output logic                        req_ok
);
	import mem_ops_pkg::*;

	logic active;
	logic misaligned;

	assign active = valid && mem_req;

	// LWL/LWR/SWL/SWR may start at any byte
	always_comb begin
		misaligned = 1'b0;
		if (part_op == PART_NONE) begin
			case (size)
				SIZE_HALF: misaligned = addr[0];
				SIZE_WORD: misaligned = |addr;
				default:   misaligned = 1'b0;
			endcase
		end
	end

	assign addr_err_load  = active && !wr && misaligned;
	assign addr_err_store = active && wr && misaligned;
	assign req_ok         = active && !misaligned;

endmodule

`default_nettype wire

/* logic/exc_handler.sv */
`timescale 1ns/10ps
`include "mem_config.svh"
`default_nettype none

module exc_handler (
	input  wire                       valid,
	input  wire [31:0]                addr,
	input  wire                       addr_err_load,
	input  wire                       addr_err_store,
	input  wire                       reserved_instr,
	input  wire                       intovf,
	input  wire                       is_break,
	input  wire                       is_syscall,
	input  wire                       is_eret,
	input  wire                       is_mtc0,
	input  wire cp0_pkg::cp0_status_u status,
	input  wire [31:0]                cause,
	input  wire [31:0]                epc,
	output logic                      exc_valid,
	output logic [31:0]               exc_addr,
	output cp0_pkg::cp0_op_t          cp0_op,
	output cp0_pkg::exc_code_t        exc_code,
	output logic                      badvaddr_wen,
	output logic [31:0]               badvaddr
);
	import cp0_pkg::*;

	logic int_pending;
	logic exc_any;

	assign int_pending = status.f.ie && !status.f.exl && |(cause[15:8] & status.f.im);

	// Interrupt first, then address error, RI, Ov, Bp, Sys
	always_comb begin
		exc_any  = 1'b1;
		exc_code = EXC_INT;
		if (int_pending) begin
			exc_code = EXC_INT;
		end else if (addr_err_load) begin
			exc_code = EXC_ADEL;
		end else if (addr_err_store) begin
			exc_code = EXC_ADES;
		end else if (reserved_instr) begin
			exc_code = EXC_RI;
		end else if (intovf) begin
			exc_code = EXC_OV;
		end else if (is_break) begin
			exc_code = EXC_BP;
		end else if (is_syscall) begin
			exc_code = EXC_SYS;
		end else begin
			exc_any = 1'b0;
		end
	end

	always_comb begin
		cp0_op = CP0_NONE;
		if (valid) begin
			if (exc_any) begin
				cp0_op = CP0_EXC;
			end else if (is_eret) begin
				cp0_op = CP0_ERET;
			end else if (is_mtc0) begin
				cp0_op = CP0_MTC0;
			end
		end
	end

	assign exc_valid = valid && (exc_any || is_eret);
	assign exc_addr  = (is_eret && !exc_any) ? epc : `MEM_EXC_VECTOR;

	// BadVAddr only for data address errors
	assign badvaddr_wen = cp0_op == CP0_EXC && (exc_code == EXC_ADEL || exc_code == EXC_ADES);
	assign badvaddr     = addr;

endmodule

`default_nettype wire

/* logic/load_extend.sv */
`timescale 1ns/10ps
`default_nettype none

module load_extend (
	input  wire mem_ops_pkg::mem_size_t size,
	input  wire mem_ops_pkg::part_op_t  part_op,
	input  wire                         load_signed,
	input  wire [1:0]                   offset,
	input  wire [31:0]                  rdata,
	input  wire [31:0]                  rt_data,
	output logic [31:0]                 result
);
	import mem_ops_pkg::*;

	logic [31:0] shifted;
	logic [7:0]  byte_val;
	logic [15:0] half_val;

	assign shifted  = rdata >> {offset, 3'b000};
	assign byte_val = shifted[7:0];
	assign half_val = offset[1] ? rdata[31:16] : rdata[15:0];

	always_comb begin
		result = rdata;
		case (part_op)
			// Memory bytes fill the top of rt
			PART_LEFT: begin
				case (offset)
					2'd0: result = {rdata[7:0], rt_data[23:0]};
					2'd1: result = {rdata[15:0], rt_data[15:0]};
					2'd2: result = {rdata[23:0], rt_data[7:0]};
					default: result = rdata;
				endcase
			end
			// Memory bytes fill the bottom of rt
			PART_RIGHT: begin
				case (offset)
					2'd1: result = {rt_data[31:24], rdata[31:8]};
					2'd2: result = {rt_data[31:16], rdata[31:16]};
					2'd3: result = {rt_data[31:8], rdata[31:24]};
					default: result = rdata;
				endcase
			end
			default: begin
				case (size)
					SIZE_BYTE: result = {{24{load_signed & byte_val[7]}}, byte_val};
					SIZE_HALF: result = {{16{load_signed & half_val[15]}}, half_val};
					default:   result = rdata;
				endcase
			end
		endcase
	end

endmodule

`default_nettype wire

/* logic/mem_config.svh */
`ifndef MEM_CONFIG_SVH
`define MEM_CONFIG_SVH

`default_nettype none

// Entry point for all exceptions and interrupts
`define MEM_EXC_VECTOR 32'hBFC0_0380

// BEV and EXL set
`define MEM_STATUS_RESET 32'h0040_0002

// Count ticks once every this many cycles
`define MEM_COUNT_DIV 2

`default_nettype wire

`endif

/* logic/mem_ops_pkg.sv */
`default_nettype none

package mem_ops_pkg;

	// Same encoding as the data port size code
	typedef enum logic [1:0] {
		SIZE_BYTE = 2'd0,
		SIZE_HALF = 2'd1,
		SIZE_WORD = 2'd2
	} mem_size_t;

	// LEFT marks LWL/SWL, RIGHT marks LWR/SWR
	typedef enum logic [1:0] {
		PART_NONE  = 2'd0,
		PART_LEFT  = 2'd1,
		PART_RIGHT = 2'd2
	} part_op_t;

endpackage

`default_nettype wire

/* logic/mem_stage.sv */
`timescale 1ns/10ps
`default_nettype none

module mem_stage (
	input  wire                         clk,
	input  wire                         rst_n,
	input  wire [5:0]                   ext_int,
	input  wire                         stall,
	input  wire                         in_valid,
	input  wire                         mem_req,
	input  wire                         mem_wr,
	input  wire mem_ops_pkg::mem_size_t size,
	input  wire mem_ops_pkg::part_op_t  part_op,
	input  wire                         load_signed,
	input  wire [31:0]                  addr,
	input  wire [31:0]                  rt_data,
	input  wire [31:0]                  pc,
	input  wire                         in_delay_slot,
	input  wire                         reserved_instr,
	input  wire                         intovf,
	input  wire                         is_break,
	input  wire                         is_syscall,
	input  wire                         is_eret,
	input  wire                         is_mfc0,
	input  wire                         is_mtc0,
	input  wire [4:0]                   cp0_addr,
	output logic                        data_req,
	output logic                        data_wr,
	output logic [1:0]                  data_size,
	output logic [31:0]                 data_addr,
	output logic [31:0]                 data_wdata,
	input  wire [31:0]                  data_rdata,
	output logic [31:0]                 load_data,
	output logic [31:0]                 cp0_rdata,
	output logic                        exc_valid,
	output logic [31:0]                 exc_addr
);
	import cp0_pkg::*;

	logic        addr_err_load;
	logic        addr_err_store;
	logic        req_ok;
	logic [1:0]  port_offset;
	cp0_op_t     cp0_op;
	exc_code_t   exc_code;
	logic        badvaddr_wen;
	logic [31:0] badvaddr;
	cp0_status_u status;
	logic [31:0] cause;
	logic [31:0] epc;
	logic [31:0] cp0_rd;

	data_addr_check i_data_addr_check (
		.valid(in_valid),
		.mem_req(mem_req),
		.wr(mem_wr),
		.size(size),
		.part_op(part_op),
		.addr(addr[1:0]),
		.addr_err_load(addr_err_load),
		.addr_err_store(addr_err_store),
		.req_ok(req_ok)
	);

	store_align i_store_align (
		.size(size),
		.part_op(part_op),
		.offset(addr[1:0]),
		.rt_data(rt_data),
		.port_size(data_size),
		.port_offset(port_offset),
		.wdata(data_wdata)
	);

	load_extend i_load_extend (
		.size(size),
		.part_op(part_op),
		.load_signed(load_signed),
		.offset(addr[1:0]),
		.rdata(data_rdata),
		.rt_data(rt_data),
		.result(load_data)
	);

	exc_handler i_exc_handler (
		.valid(in_valid),
		.addr(addr),
		.addr_err_load(addr_err_load),
		.addr_err_store(addr_err_store),
		.reserved_instr(reserved_instr),
		.intovf(intovf),
		.is_break(is_break),
		.is_syscall(is_syscall),
		.is_eret(is_eret),
		.is_mtc0(is_mtc0),
		.status(status),
		.cause(cause),
		.epc(epc),
		.exc_valid(exc_valid),
		.exc_addr(exc_addr),
		.cp0_op(cp0_op),
		.exc_code(exc_code),
		.badvaddr_wen(badvaddr_wen),
		.badvaddr(badvaddr)
	);

	cp0_regfile i_cp0_regfile (
		.clk(clk),
		.rst_n(rst_n),
		.stall(stall),
		.ext_int(ext_int),
		.cp0_op(cp0_op),
		.exc_code(exc_code),
		.pc(pc),
		.in_delay_slot(in_delay_slot),
		.badvaddr_wen(badvaddr_wen),
		.badvaddr(badvaddr),
		.raddr(cp0_addr),
		.waddr(cp0_addr),
		.wdata(rt_data),
		.rdata(cp0_rd),
		.status(status),
		.cause(cause),
		.epc(epc)
	);

	// No request goes out for a flushed instruction
	assign data_req  = req_ok && !exc_valid;
	assign data_wr   = mem_wr;
	assign data_addr = {addr[31:2], port_offset};
	assign cp0_rdata = is_mfc0 ? cp0_rd : 32'd0;

endmodule

`default_nettype wire

/* logic/store_align.sv */
`timescale 1ns/10ps
`default_nettype none

module store_align (
	input  wire mem_ops_pkg::mem_size_t size,
	input  wire mem_ops_pkg::part_op_t  part_op,
	input  wire [1:0]                   offset,
	input  wire [31:0]                  rt_data,
	output logic [1:0]                  port_size,
	output logic [1:0]                  port_offset,
	output logic [31:0]                 wdata
);
	import mem_ops_pkg::*;

	// Three-byte writes use word size with a nonzero offset
	// offset 1 covers bytes 3:1, offset 2 covers bytes 2:0
	always_comb begin
		port_size   = SIZE_WORD;
		port_offset = offset;
		wdata       = rt_data;
		case (part_op)
			PART_LEFT: begin
				wdata = rt_data >> {~offset, 3'b000};
				case (offset)
					2'd0: port_size = SIZE_BYTE;
					2'd1: port_size = SIZE_HALF;
					default: port_size = SIZE_WORD;
				endcase
				// Only the three-byte case keeps its offset
				port_offset = (offset == 2'd2) ? 2'd2 : 2'd0;
			end
			PART_RIGHT: begin
				wdata = rt_data << {offset, 3'b000};
				case (offset)
					2'd2: port_size = SIZE_HALF;
					2'd3: port_size = SIZE_BYTE;
					default: port_size = SIZE_WORD;
				endcase
			end
			default: begin
				port_size = size;
				case (size)
					SIZE_BYTE: wdata = {4{rt_data[7:0]}};
					SIZE_HALF: wdata = {2{rt_data[15:0]}};
					default:   wdata = rt_data;
				endcase
			end
		endcase
	end

endmodule

`default_nettype wire

/* mem_stage.f */
+incdir+logic
logic/mem_ops_pkg.sv
logic/cp0_pkg.sv
logic/data_addr_check.sv
logic/store_align.sv
logic/load_extend.sv
logic/exc_handler.sv
logic/cp0_regfile.sv
logic/mem_stage.sv
tests/mem_stage_props.sv
tests/mem_stage_tb.sv

/* tests/mem_stage_props.sv */
`timescale 1ns/10ps
`include "mem_config.svh"
`default_nettype none

module mem_stage_props (
	input wire                   clk,
	input wire                   rst_n,
	input wire                   in_valid,
	input wire                   reserved_instr,
	input wire                   intovf,
	input wire                   is_break,
	input wire                   is_syscall,
	input wire cp0_pkg::cp0_op_t cp0_op,
	input wire                   data_req,
	input wire                   exc_valid,
	input wire [31:0]            exc_addr,
	input wire [31:0]            epc
);
	import cp0_pkg::*;

	// A flushed instruction never reaches memory
	req_vs_exc: assert property (@(posedge clk) disable iff (!rst_n)
		in_valid && (reserved_instr || intovf || is_break || is_syscall)
			|-> exc_valid && !data_req)
		else $error("excepting instruction was not flushed or still requested memory");

	// Only ERET returns to EPC
	redirect_target: assert property (@(posedge clk) disable iff (!rst_n)
		exc_valid |-> exc_addr == ((cp0_op == CP0_ERET) ? epc : `MEM_EXC_VECTOR))
		else $error("exc_addr does not match the redirect kind");

	idle_no_req: assert property (@(posedge clk) disable iff (!rst_n)
		!in_valid |-> !data_req)
		else $error("data_req high without a valid instruction");

endmodule

bind mem_stage mem_stage_props i_mem_stage_props (
	.clk(clk),
	.rst_n(rst_n),
	.in_valid(in_valid),
	.reserved_instr(reserved_instr),
	.intovf(intovf),
	.is_break(is_break),
	.is_syscall(is_syscall),
	.cp0_op(cp0_op),
	.data_req(data_req),
	.exc_valid(exc_valid),
	.exc_addr(exc_addr),
	.epc(epc)
);

`default_nettype wire

/* tests/mem_stage_tb.sv */
`timescale 1ns/10ps
`include "mem_config.svh"
`default_nettype none

module mem_stage_tb;
	import mem_ops_pkg::*;

	localparam int PERIOD = 40;
	localparam int DRIVE_DELAY = 2;
	localparam logic [31:0] STATUS_WMASK = 32'h0040_FF03;

	typedef enum logic [3:0] {
		OP_NOP, OP_SB, OP_SH, OP_SW, OP_SWL, OP_SWR, OP_LB, OP_LH, OP_LW, OP_LWL, OP_LWR,
		OP_MFC0, OP_MTC0, OP_ERET
	} op_t;

	// Stimulus fields first, expected responses after
	typedef struct packed {
		op_t         op;
		logic        sgn;
		logic [31:0] addr;
		logic [31:0] rt;
		logic [31:0] mem;
		logic [31:0] pc;
		logic [3:0]  flags;
		logic [4:0]  creg;
		logic        dslot;
		logic        stall;
		logic [5:0]  ext;
		logic        req;
		logic [1:0]  dsize;
		logic [1:0]  dlow;
		logic [31:0] wdata;
		logic [31:0] ldata;
		logic [31:0] crd;
		logic        exc;
		logic [31:0] eaddr;
	} entry_t;

	logic        clk;
	logic        rst_n;
	logic [5:0]  ext_int;
	logic        stall;
	logic        in_valid;
	logic        mem_req;
	logic        mem_wr;
	mem_size_t   size;
	part_op_t    part_op;
	logic        load_signed;
	logic [31:0] addr;
	logic [31:0] rt_data;
	logic [31:0] pc;
	logic        in_delay_slot;
	logic        reserved_instr;
	logic        intovf;
	logic        is_break;
	logic        is_syscall;
	logic        is_eret;
	logic        is_mfc0;
	logic        is_mtc0;
	logic [4:0]  cp0_addr;
	logic        data_req;
	logic        data_wr;
	logic [1:0]  data_size;
	logic [31:0] data_addr;
	logic [31:0] data_wdata;
	logic [31:0] data_rdata;
	logic [31:0] load_data;
	logic [31:0] cp0_rdata;
	logic        exc_valid;
	logic [31:0] exc_addr;

	entry_t      tbl[$];
	integer      seed = 32'h4d70_9565;
	int          errors;
	logic        table_ready = 1'b0;

	// Reference CP0 state
	logic [31:0] m_status;
	logic [31:0] m_epc;
	logic [31:0] m_bad;
	logic [4:0]  m_exc;
	logic        m_bd;
	logic [5:0]  m_ip;

	mem_stage i_mem_stage (
		.clk(clk),
		.rst_n(rst_n),
		.ext_int(ext_int),
		.stall(stall),
		.in_valid(in_valid),
		.mem_req(mem_req),
		.mem_wr(mem_wr),
		.size(size),
		.part_op(part_op),
		.load_signed(load_signed),
		.addr(addr),
		.rt_data(rt_data),
		.pc(pc),
		.in_delay_slot(in_delay_slot),
		.reserved_instr(reserved_instr),
		.intovf(intovf),
		.is_break(is_break),
		.is_syscall(is_syscall),
		.is_eret(is_eret),
		.is_mfc0(is_mfc0),
		.is_mtc0(is_mtc0),
		.cp0_addr(cp0_addr),
		.data_req(data_req),
		.data_wr(data_wr),
		.data_size(data_size),
		.data_addr(data_addr),
		.data_wdata(data_wdata),
		.data_rdata(data_rdata),
		.load_data(load_data),
		.cp0_rdata(cp0_rdata),
		.exc_valid(exc_valid),
		.exc_addr(exc_addr)
	);

	initial begin
		clk = 1'b0;
		forever #(PERIOD / 2) clk = ~clk;
	end

	task automatic check_value(input string what, input logic [31:0] got,
			input logic [31:0] exp);
		if (got !== exp) begin
			errors++;
			$display("FAILED at %0t: %s is %h, expected %h", $time, what, got, exp);
			$display("*** FAILED ***");
			$fatal(1, "stopped at the first mismatch");
		end
	endtask

	task automatic add_entry(input op_t op, input logic sgn, input logic [31:0] a,
			input logic [31:0] rt, input logic [3:0] flags, input logic [4:0] creg,
			input logic dslot, input logic stall_in, input logic [5:0] ext);
		entry_t      e;
		logic        is_st;
		logic        is_ld;
		logic        mis;
		logic        irq;
		logic        exc_any;
		logic [4:0]  code;
		logic [7:0]  b;
		logic [15:0] h;
		int          o;
		int          n;
		int          first;
		e = '0;
		e.op = op;
		e.sgn = sgn;
		e.addr = a;
		e.rt = rt;
		e.mem = $random(seed);
		e.pc = 32'h0040_0000 + 32'(tbl.size()) * 32'd4;
		e.flags = flags;
		e.creg = creg;
		e.dslot = dslot;
		e.stall = stall_in;
		e.ext = ext;
		is_st = op inside {OP_SB, OP_SH, OP_SW, OP_SWL, OP_SWR};
		is_ld = op inside {OP_LB, OP_LH, OP_LW, OP_LWL, OP_LWR};
		o = int'(a[1:0]);
		mis = ((op == OP_SH || op == OP_LH) && a[0]) || ((op == OP_SW || op == OP_LW) && o != 0);
		irq = m_status[0] && !m_status[1] && (({m_ip, 2'b00} & m_status[15:8]) != 8'd0);

		// Interrupt, address error, RI, Ov, Bp, Sys
		code = 5'd0;
		if (irq)
			code = 5'd0;
		else if (mis)
			code = is_st ? 5'd5 : 5'd4;
		else if (flags[3])
			code = 5'd10;
		else if (flags[2])
			code = 5'd12;
		else if (flags[1])
			code = 5'd9;
		else if (flags[0])
			code = 5'd8;
		exc_any = irq || mis || (flags != 4'd0);
		e.exc = exc_any || op == OP_ERET;
		e.eaddr = (op == OP_ERET && !exc_any) ? m_epc : `MEM_EXC_VECTOR;
		e.req = (is_st || is_ld) && !exc_any;

		// Bytes touched and the first byte
		n = 4;
		first = o;
		case (op)
			OP_SB, OP_LB: n = 1;
			OP_SH, OP_LH: n = 2;
			OP_SWL, OP_LWL: begin
				n = o + 1;
				first = 0;
			end
			OP_SWR, OP_LWR: n = 4 - o;
			default: n = 4;
		endcase
		e.dsize = (n == 1) ? 2'd0 : (n == 2) ? 2'd1 : 2'd2;
		// Three bytes go out as a word, offset 2 for 2:0 and 1 for 3:1
		e.dlow = (n == 3) ? ((first == 0) ? 2'd2 : 2'd1) : 2'(first);

		case (op)
			OP_SB: e.wdata = {4{rt[7:0]}};
			OP_SH: e.wdata = {2{rt[15:0]}};
			OP_SWL: e.wdata = rt >> (8 * (3 - o));
			OP_SWR: e.wdata = rt << (8 * o);
			default: e.wdata = rt;
		endcase

		b = 8'(e.mem >> (8 * o));
		h = 16'(e.mem >> (8 * o));
		case (op)
			OP_LB: e.ldata = {{24{sgn & b[7]}}, b};
			OP_LH: e.ldata = {{16{sgn & h[15]}}, h};
			OP_LWL: e.ldata = (e.mem << (8 * (3 - o))) | (rt & (32'hFFFF_FFFF >> (8 * (o + 1))));
			OP_LWR: e.ldata = (e.mem >> (8 * o)) | (rt & ~(32'hFFFF_FFFF >> (8 * o)));
			default: e.ldata = e.mem;
		endcase

		if (op == OP_MFC0) begin
			case (creg)
				5'd8: e.crd = m_bad;
				5'd12: e.crd = m_status;
				5'd13: e.crd = {m_bd, 1'b0, 14'd0, m_ip, 2'b00, 1'b0, m_exc, 2'b00};
				5'd14: e.crd = m_epc;
				default: e.crd = 32'd0;
			endcase
		end

		if (!stall_in) begin
			if (exc_any) begin
				m_status[1] = 1'b1;
				m_bd = dslot;
				m_exc = code;
				m_epc = dslot ? e.pc - 32'd4 : e.pc;
				if (code == 5'd4 || code == 5'd5)
					m_bad = a;
			end else if (op == OP_ERET) begin
				m_status[1] = 1'b0;
			end else if (op == OP_MTC0 && creg == 5'd12) begin
				m_status = (m_status & ~STATUS_WMASK) | (rt & STATUS_WMASK);
			end else if (op == OP_MTC0 && creg == 5'd14) begin
				m_epc = rt;
			end
			m_ip = ext;
		end
		tbl.push_back(e);
	endtask

	task automatic add_access(input op_t op, input logic sgn, input logic [31:0] a);
		add_entry(op, sgn, a, $random(seed), 4'h0, 5'd0, 1'b0, 1'b0, 6'd0);
	endtask

	task automatic add_mfc0(input logic [4:0] creg);
		add_entry(OP_MFC0, 1'b0, 32'd0, $random(seed), 4'h0, creg, 1'b0, 1'b0, 6'd0);
	endtask

	task automatic add_mtc0(input logic [4:0] creg, input logic [31:0] value);
		add_entry(OP_MTC0, 1'b0, 32'd0, value, 4'h0, creg, 1'b0, 1'b0, 6'd0);
	endtask

	task automatic build_table();
		logic [31:0] a;
		for (int o = 0; o < 4; o++) begin
			a = 32'h1000_0040 + 32'(o);
			add_access(OP_SB, 1'b0, a);
			add_access(OP_SH, 1'b0, a);
			add_access(OP_SW, 1'b0, a);
			add_access(OP_SWL, 1'b0, a);
			add_access(OP_SWR, 1'b0, a);
			add_access(OP_LB, 1'b1, a);
			add_access(OP_LB, 1'b0, a);
			add_access(OP_LH, 1'b1, a);
			add_access(OP_LH, 1'b0, a);
			add_access(OP_LW, 1'b0, a);
			add_access(OP_LWL, 1'b0, a);
			add_access(OP_LWR, 1'b0, a);
		end
		add_access(OP_LH, 1'b1, 32'h1000_0083);
		add_mfc0(5'd8);
		add_mfc0(5'd13);
		add_mfc0(5'd14);
		// Store in a delay slot
		add_entry(OP_SW, 1'b0, 32'h1000_00C6, $random(seed), 4'h0, 5'd0, 1'b1, 1'b0, 6'd0);
		add_mfc0(5'd8);
		add_mfc0(5'd13);
		add_mfc0(5'd14);
		// Several causes on one instruction
		add_entry(OP_NOP, 1'b0, 32'd0, $random(seed), 4'b1111, 5'd0, 1'b0, 1'b0, 6'd0);
		add_mfc0(5'd13);
		add_entry(OP_NOP, 1'b0, 32'd0, $random(seed), 4'b0111, 5'd0, 1'b0, 1'b0, 6'd0);
		add_mfc0(5'd13);
		add_entry(OP_NOP, 1'b0, 32'd0, $random(seed), 4'b0011, 5'd0, 1'b0, 1'b0, 6'd0);
		add_mfc0(5'd13);
		add_entry(OP_NOP, 1'b0, 32'd0, $random(seed), 4'b0001, 5'd0, 1'b0, 1'b0, 6'd0);
		add_mfc0(5'd13);
		add_entry(OP_LW, 1'b0, 32'h1000_0101, $random(seed), 4'b1111, 5'd0, 1'b0, 1'b0, 6'd0);
		add_mfc0(5'd13);
		add_mfc0(5'd8);
		// Status writes and ERET
		add_mtc0(5'd12, 32'hFFFF_FFFC);
		add_mfc0(5'd12);
		add_mtc0(5'd14, 32'h0040_1230);
		add_mtc0(5'd12, 32'h0000_AB02);
		add_mfc0(5'd12);
		add_entry(OP_ERET, 1'b0, 32'd0, $random(seed), 4'h0, 5'd0, 1'b0, 1'b0, 6'd0);
		add_mfc0(5'd12);
		// External interrupt on IP2 beats every other cause
		add_mtc0(5'd12, 32'h0000_FF01);
		add_entry(OP_NOP, 1'b0, 32'd0, $random(seed), 4'h0, 5'd0, 1'b0, 1'b0, 6'd1);
		add_entry(OP_LW, 1'b0, 32'h1000_0143, $random(seed), 4'b1111, 5'd0, 1'b0, 1'b0, 6'd1);
		add_mfc0(5'd13);
		add_mfc0(5'd14);
		add_mfc0(5'd8);
		// Stalled writes must not land
		add_entry(OP_MTC0, 1'b0, 32'd0, 32'h0000_0001, 4'h0, 5'd12, 1'b0, 1'b1, 6'd0);
		add_entry(OP_NOP, 1'b0, 32'd0, $random(seed), 4'b0001, 5'd0, 1'b0, 1'b1, 6'h3F);
		add_entry(OP_MFC0, 1'b0, 32'd0, $random(seed), 4'h0, 5'd12, 1'b0, 1'b1, 6'd0);
		add_entry(OP_MFC0, 1'b0, 32'd0, $random(seed), 4'h0, 5'd13, 1'b0, 1'b1, 6'd0);
		add_mfc0(5'd14);
		add_entry(OP_ERET, 1'b0, 32'd0, $random(seed), 4'h0, 5'd0, 1'b0, 1'b0, 6'd0);
		add_mfc0(5'd12);
	endtask

	task automatic drive_idle();
		ext_int = 6'd0;
		stall = 1'b0;
		in_valid = 1'b0;
		mem_req = 1'b0;
		mem_wr = 1'b0;
		size = SIZE_WORD;
		part_op = PART_NONE;
		load_signed = 1'b0;
		addr = 32'd0;
		rt_data = 32'd0;
		pc = 32'd0;
		in_delay_slot = 1'b0;
		reserved_instr = 1'b0;
		intovf = 1'b0;
		is_break = 1'b0;
		is_syscall = 1'b0;
		is_eret = 1'b0;
		is_mfc0 = 1'b0;
		is_mtc0 = 1'b0;
		cp0_addr = 5'd0;
		data_rdata = 32'd0;
	endtask

	task automatic apply_entry(input entry_t e);
		in_valid = 1'b1;
		mem_req = e.op inside {OP_SB, OP_SH, OP_SW, OP_SWL, OP_SWR,
			OP_LB, OP_LH, OP_LW, OP_LWL, OP_LWR};
		mem_wr = e.op inside {OP_SB, OP_SH, OP_SW, OP_SWL, OP_SWR};
		case (e.op)
			OP_SB, OP_LB: size = SIZE_BYTE;
			OP_SH, OP_LH: size = SIZE_HALF;
			default: size = SIZE_WORD;
		endcase
		case (e.op)
			OP_SWL, OP_LWL: part_op = PART_LEFT;
			OP_SWR, OP_LWR: part_op = PART_RIGHT;
			default: part_op = PART_NONE;
		endcase
		load_signed = e.sgn;
		addr = e.addr;
		rt_data = e.rt;
		pc = e.pc;
		in_delay_slot = e.dslot;
		reserved_instr = e.flags[3];
		intovf = e.flags[2];
		is_break = e.flags[1];
		is_syscall = e.flags[0];
		is_eret = e.op == OP_ERET;
		is_mfc0 = e.op == OP_MFC0;
		is_mtc0 = e.op == OP_MTC0;
		cp0_addr = e.creg;
		data_rdata = e.mem;
		stall = e.stall;
		ext_int = e.ext;
	endtask

	task automatic compare_outputs(input entry_t e);
		logic is_st;
		is_st = e.op inside {OP_SB, OP_SH, OP_SW, OP_SWL, OP_SWR};
		check_value("exc_valid", 32'(exc_valid), 32'(e.exc));
		if (e.exc)
			check_value("exc_addr", exc_addr, e.eaddr);
		check_value("data_req", 32'(data_req), 32'(e.req));
		check_value("cp0_rdata", cp0_rdata, e.crd);
		if (e.req) begin
			check_value("data_wr", 32'(data_wr), 32'(is_st));
			check_value("data_size", 32'(data_size), 32'(e.dsize));
			check_value("data_addr", data_addr, {e.addr[31:2], e.dlow});
			if (is_st)
				check_value("data_wdata", data_wdata, e.wdata);
			else
				check_value("load_data", load_data, e.ldata);
		end
	endtask

	initial begin
		wait (table_ready);
		repeat (tbl.size() * 4 + 100) @(posedge clk);
		$display("Timeout: the stimulus table did not finish in time");
		$display("*** FAILED ***");
		$fatal(1, "watchdog expired");
	end

	initial begin
		drive_idle();
		rst_n = 1'b0;
		errors = 0;
		m_status = `MEM_STATUS_RESET;
		m_epc = 32'd0;
		m_bad = 32'd0;
		m_exc = 5'd0;
		m_bd = 1'b0;
		m_ip = 6'd0;
		build_table();
		table_ready = 1'b1;
		repeat (2) @(posedge clk);
		#DRIVE_DELAY;
		rst_n = 1'b1;
		repeat (2) @(posedge clk);
		foreach (tbl[i]) begin
			@(posedge clk);
			#DRIVE_DELAY;
			apply_entry(tbl[i]);
			@(negedge clk);
			compare_outputs(tbl[i]);
		end
		@(posedge clk);
		#DRIVE_DELAY;
		drive_idle();
		repeat (2) @(posedge clk);
		if (errors == 0) begin
			$display("*** PASSED ***");
			$finish;
		end else begin
			$display("*** FAILED ***");
			$fatal(1, "%0d mismatches", errors);
		end
	end

endmodule

`default_nettype wire
